/* files.f */
+incdir+common
common/cpu_pkg.sv
design/if_stage.sv
design/decoder.sv
design/id_reg.sv
design/gpr.sv
design/alu.sv
design/mem_ctrl.sv
design/spm/spm.sv
design/cpu_two_pipeline_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP      := cpu_tb
FILELIST := files.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* verification/cpu_tb.sv */
`include "cpu_settings.svh"

`default_nettype none

module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN   = 64;     // words 0..63 hold code
    localparam int BODY_LEN   = 30;     // random part before the register dump
    localparam int DATA_BASE  = 64;     // target of random loads and stores
    localparam int DUMP_BASE  = 96;     // r0..r31 stored here at the end
    localparam int REGION     = 128;
    localparam int NUM_PROGS  = 3;
    localparam int RUN_CYCLES = 2 * (BODY_LEN + 33) + 4;
    // twice the expected length of the whole run
    localparam int MAX_CYCLES = 2 * (NUM_PROGS * RUN_CYCLES + (NUM_PROGS + 1) * (2 * REGION + 8));

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cpu_en;
    cpu_pkg::spm_req_t test_req;
    cpu_pkg::word_t    test_spm_rd_data;

    cpu_pkg::word_t exp_mem [`SPM_DEPTH];  // expected scratchpad image
    logic [31:0]    lfsr = 32'hc241_84b5;
    logic           chk_en;
    logic [9:0]     chk_idx;
    int             n_checks;
    int             n_errors;
    int             n_props;
    int             cycles = 0;

    always #4 clk = ~clk;

    cpu_two_pipeline_top u_cpu_two_pipeline_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .cpu_en           (cpu_en),
        .test_req         (test_req),
        .test_spm_rd_data (test_spm_rd_data)
    );

    bind cpu_two_pipeline_top cpu_props u_cpu_props (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_en   (cpu_en),
        .cpu_req  (cpu_req),
        .br_taken (br_taken),
        .if_valid (if_valid)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic cpu_pkg::insn_t encode(input logic [5:0] op, input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t ra, input logic [15:0] imm);
        return {op, rd, ra, imm};
    endfunction

    // instruction-set model, runs the image in place until the jump to self
    function automatic void run_model();
        cpu_pkg::word_t    regs [32];
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    imm;
        cpu_pkg::word_t    addr;
        cpu_pkg::insn_t    insn;
        logic [5:0]        op;
        cpu_pkg::reg_idx_t rd;
        logic [9:0]        pc;
        pc = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int step = 0; step < 4 * PROG_LEN; step++) begin
            insn = exp_mem[pc];
            op   = insn[31:26];
            rd   = insn[25:21];
            a    = regs[insn[20:16]];
            b    = regs[insn[15:11]];
            imm  = {{16{insn[15]}}, insn[15:0]};
            addr = a + imm;
            if (op == `OP_JMP && imm == '1) begin
                break;
            end
            pc = pc + 10'd1;
            case (op)
                `OP_ADD:   regs[rd] = a + b;
                `OP_SUB:   regs[rd] = a - b;
                `OP_AND:   regs[rd] = a & b;
                `OP_OR:    regs[rd] = a | b;
                `OP_XOR:   regs[rd] = a ^ b;
                `OP_SHL:   regs[rd] = a << b[4:0];
                `OP_ADDI:  regs[rd] = a + imm;
                `OP_LOAD:  if (addr[1:0] == 2'b00) regs[rd] = exp_mem[addr[11:2]];
                `OP_STORE: if (addr[1:0] == 2'b00) exp_mem[addr[11:2]] = regs[rd];
                `OP_BEQ:   if (a == regs[rd]) pc = pc + imm[9:0];
                `OP_JMP:   pc = pc + imm[9:0];
                default: ;
            endcase
            regs[0] = '0;
        end
    endfunction

    // kind 0 alu, 1 memory, 2 branch
    task automatic gen_program(input int kind);
        logic [5:0]        op;
        logic [5:0]        prev_op;
        logic [15:0]       imm;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t ra;
        cpu_pkg::reg_idx_t prev_rd;
        int                sel;
        prev_op = `OP_NOP;
        prev_rd = '0;
        for (int i = 0; i < BODY_LEN; i++) begin
            rd  = 5'(rand_bits(kind == 0 ? 5 : 3));
            ra  = rand_bits(1) != 0 ? prev_rd : 5'(rand_bits(5));   // often the last result
            imm = 16'(rand_bits(16));
            sel = int'(rand_bits(3));
            case (kind)
                0: op = (sel == 7) ? `OP_ADDI : 6'(`OP_ADD + sel);
                1: begin
                    op = (sel < 2) ? `OP_ADDI : (sel < 5) ? `OP_LOAD : `OP_STORE;
                    if (op != `OP_ADDI) begin
                        ra  = '0;
                        imm = 16'((DATA_BASE + int'(rand_bits(5))) * 4);
                        if (rand_bits(2) == 0) begin
                            imm = imm + 16'(rand_bits(2));   // sometimes misaligned
                        end
                    end
                    if (prev_op == `OP_LOAD) begin
                        op  = `OP_ADD;
                        ra  = prev_rd;
                        imm = {5'(rand_bits(3)), 11'd0};
                    end
                end
                default: begin
                    rd  = 5'(rand_bits(2));
                    imm = 16'(rand_bits(2));
                    op  = (sel < 4) ? `OP_ADDI : (sel < 7) ? `OP_BEQ : `OP_JMP;
                    ra  = (op == `OP_ADDI) ? (rand_bits(1) != 0 ? rd : 5'd0) : 5'(rand_bits(2));
                end
            endcase
            exp_mem[i] = encode(op, rd, ra, imm);
            prev_op    = op;
            prev_rd    = rd;
        end
        for (int r = 0; r < 32; r++) begin
            exp_mem[BODY_LEN + r] = encode(`OP_STORE, 5'(r), 5'd0, 16'((DUMP_BASE + r) * 4));
        end
        exp_mem[BODY_LEN + 32] = encode(`OP_JMP, 5'd0, 5'd0, 16'hffff);   // jump to self
        for (int i = BODY_LEN + 33; i < PROG_LEN; i++) begin
            exp_mem[i] = '0;
        end
    endtask

    task automatic check(input string name, input cpu_pkg::word_t exp, input cpu_pkg::word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic write_region();
        for (int i = 0; i < REGION; i++) begin
            @(posedge clk);
            test_req <= '{as_: 1'b0, rw: 1'b1, addr: cpu_pkg::waddr_t'(i), wr_data: exp_mem[i]};
        end
        @(posedge clk);
        test_req.as_ <= 1'b1;
    endtask

    task automatic read_region();
        for (int i = 0; i < REGION; i++) begin
            @(posedge clk);
            test_req <= '{as_: 1'b0, rw: 1'b0, addr: cpu_pkg::waddr_t'(i), wr_data: '0};
            chk_idx  <= 10'(i);
            chk_en   <= 1'b1;
        end
        @(posedge clk);
        test_req.as_ <= 1'b1;
        chk_en       <= 1'b0;
    endtask

    task automatic run_program(input int kind);
        gen_program(kind);
        write_region();
        run_model();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n  <= 1'b1;
        cpu_en <= 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        cpu_en <= 1'b0;
        read_region();
    endtask

    // readback and port checks, away from the driving edge
    always @(negedge clk) begin
        if (chk_en) begin
            check($sformatf("spm[%0d]", chk_idx), exp_mem[chk_idx], test_spm_rd_data);
        end
        if (cpu_en) begin
            check("test_spm_rd_data", '0, test_spm_rd_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        cpu_en   = 1'b0;
        test_req = '{as_: 1'b1, rw: 1'b0, addr: '0, wr_data: '0};
        chk_en   = 1'b0;
        chk_idx  = '0;
        n_checks = 0;
        n_errors = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // test port alone, cpu stopped
        for (int i = 0; i < REGION; i++) begin
            exp_mem[i] = rand_bits(32);
        end
        write_region();
        read_region();
        check("pc", '0, cpu_pkg::word_t'(u_cpu_two_pipeline_top.pc));

        for (int k = 0; k < NUM_PROGS; k++) begin
            run_program(k);
        end

        repeat (2) @(posedge clk);
        n_props = u_cpu_two_pipeline_top.u_cpu_props.fail_count;
        $display("%0d checks, %0d mismatches, %0d assertion failures",
                 n_checks, n_errors, n_props);
        if (n_errors == 0 && n_props == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/cpu_props.sv */
`default_nettype none

module cpu_props (
    input logic              clk,
    input logic              rst_n,
    input logic              cpu_en,
    input cpu_pkg::spm_req_t cpu_req,
    input logic              br_taken,
    input logic              if_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    strobe_idle_after_reset: assert property (@(posedge clk) !rst_n |=> cpu_req.as_)
        else begin
            fail_count++;
            $error("data strobe active right after reset");
        end

    // stalled execute slot must not touch port b
    cpu_quiet_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
                                             !cpu_en |-> cpu_req.as_)
        else begin
            fail_count++;
            $error("cpu drives a data access while stopped");
        end

    branch_squash: assert property (@(posedge clk) disable iff (!rst_n)
                                    cpu_en && br_taken |=> !if_valid)
        else begin
            fail_count++;
            $error("instruction behind a taken branch not squashed");
        end

endmodule

`default_nettype wire

/* design/cpu_two_pipeline_top.sv */
`default_nettype none

module cpu_two_pipeline_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_en,
    input  cpu_pkg::spm_req_t test_req,
    output cpu_pkg::word_t    test_spm_rd_data
);

    // fetch
    cpu_pkg::waddr_t   pc;
    cpu_pkg::insn_t    fetch_insn;
    cpu_pkg::waddr_t   if_pc;
    cpu_pkg::insn_t    if_insn;
    logic              if_valid;
    logic              br_taken;
    cpu_pkg::waddr_t   br_addr;
    // decode
    cpu_pkg::reg_idx_t gpr_rd_addr_0;
    cpu_pkg::reg_idx_t gpr_rd_addr_1;
    cpu_pkg::word_t    gpr_rd_data_0;
    cpu_pkg::word_t    gpr_rd_data_1;
    cpu_pkg::id_ctrl_t id_ctrl;
    cpu_pkg::id_ctrl_t ex_ctrl;
    // execute
    cpu_pkg::word_t    alu_out;
    cpu_pkg::wb_t      wb;
    cpu_pkg::spm_req_t cpu_req;
    cpu_pkg::spm_req_t data_req;
    cpu_pkg::word_t    mem_rd_data;

    if_stage u_if_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_en     (cpu_en),
        .br_taken   (br_taken),
        .br_addr    (br_addr),
        .fetch_insn (fetch_insn),
        .pc         (pc),
        .if_pc      (if_pc),
        .if_insn    (if_insn),
        .if_valid   (if_valid)
    );

    decoder u_decoder (
        .if_insn       (if_insn),
        .if_pc         (if_pc),
        .if_valid      (if_valid),
        .gpr_rd_addr_0 (gpr_rd_addr_0),
        .gpr_rd_addr_1 (gpr_rd_addr_1),
        .gpr_rd_data_0 (gpr_rd_data_0),
        .gpr_rd_data_1 (gpr_rd_data_1),
        .wb            (wb),
        .br_taken      (br_taken),
        .br_addr       (br_addr),
        .id_ctrl       (id_ctrl)
    );

    id_reg u_id_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu_en (cpu_en),
        .id_in  (id_ctrl),
        .id_out (ex_ctrl)
    );

    gpr u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb),
        .rd_addr_0 (gpr_rd_addr_0),
        .rd_addr_1 (gpr_rd_addr_1),
        .rd_data_0 (gpr_rd_data_0),
        .rd_data_1 (gpr_rd_data_1)
    );

    alu u_alu (
        .alu_op   (ex_ctrl.alu_op),
        .alu_in_0 (ex_ctrl.alu_in_0),
        .alu_in_1 (ex_ctrl.alu_in_1),
        .alu_out  (alu_out)
    );

    mem_ctrl u_mem_ctrl (
        .cpu_en      (cpu_en),
        .id_ctrl     (ex_ctrl),
        .alu_out     (alu_out),
        .mem_rd_data (mem_rd_data),
        .mem_req     (cpu_req),
        .wb          (wb)
    );

    spm u_spm (
        .clk         (clk),
        .if_addr     (pc),
        .if_rd_data  (fetch_insn),
        .mem_req     (data_req),
        .mem_rd_data (mem_rd_data)
    );

    // test port owns the data port while the cpu is stopped
    assign data_req         = cpu_en ? cpu_req : test_req;
    assign test_spm_rd_data = cpu_en ? '0 : mem_rd_data;

endmodule

`default_nettype wire

/* design/spm/spm.sv */
`include "cpu_settings.svh"

`default_nettype none

module spm (
    input  logic              clk,
    input  cpu_pkg::waddr_t   if_addr,
    output cpu_pkg::insn_t    if_rd_data,
    input  cpu_pkg::spm_req_t mem_req,
    output cpu_pkg::word_t    mem_rd_data
);

    localparam int IDX_W = $clog2(`SPM_DEPTH);

    cpu_pkg::word_t mem [`SPM_DEPTH];

    logic [IDX_W-1:0] if_idx;
    logic [IDX_W-1:0] mem_idx;

    // upper address bits ignored
    assign if_idx  = if_addr[IDX_W-1:0];
    assign mem_idx = mem_req.addr[IDX_W-1:0];

    // port a, fetch only
    assign if_rd_data = mem[if_idx];

    // port b
    assign mem_rd_data = mem[mem_idx];

    always_ff @(posedge clk) begin
        if (!mem_req.as_ && mem_req.rw) begin
            mem[mem_idx] <= mem_req.wr_data;
        end
    end

endmodule

`default_nettype wire

/* design/mem_ctrl.sv */
`include "cpu_settings.svh"

`default_nettype none

module mem_ctrl (
    input  logic              cpu_en,
    input  cpu_pkg::id_ctrl_t id_ctrl,
    input  cpu_pkg::word_t    alu_out,
    input  cpu_pkg::word_t    mem_rd_data,
    output cpu_pkg::spm_req_t mem_req,
    output cpu_pkg::wb_t      wb
);

    logic aligned;
    logic active;   // execute slot may act this cycle
    logic is_load;
    logic access;

    assign aligned = (alu_out[1:0] == 2'b00);
    assign active  = cpu_en && id_ctrl.valid;
    assign is_load = (id_ctrl.mem_op == cpu_pkg::MEM_LOAD);
    assign access  = active && aligned && (id_ctrl.mem_op != cpu_pkg::MEM_NONE);

    assign mem_req.as_     = !access;
    assign mem_req.rw      = (id_ctrl.mem_op == cpu_pkg::MEM_STORE);
    assign mem_req.addr    = alu_out[`DATA_WIDTH-1:2];  // drop byte offset
    assign mem_req.wr_data = id_ctrl.store_data;

    // misaligned load leaves rd untouched
    assign wb.we   = active && id_ctrl.gpr_we && !(is_load && !aligned);
    assign wb.addr = id_ctrl.dst;
    assign wb.data = is_load ? mem_rd_data : alu_out;

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::word_t   alu_in_0,
    input  cpu_pkg::word_t   alu_in_1,
    output cpu_pkg::word_t   alu_out
);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:  alu_out = alu_in_0 + alu_in_1;
            cpu_pkg::ALU_SUB:  alu_out = alu_in_0 - alu_in_1;
            cpu_pkg::ALU_AND:  alu_out = alu_in_0 & alu_in_1;
            cpu_pkg::ALU_OR:   alu_out = alu_in_0 | alu_in_1;
            cpu_pkg::ALU_XOR:  alu_out = alu_in_0 ^ alu_in_1;
            cpu_pkg::ALU_SHL:  alu_out = alu_in_0 << alu_in_1[4:0];   // 5 bit amount
            cpu_pkg::ALU_THRU: alu_out = alu_in_0;
            default:           alu_out = alu_in_0;
        endcase
    end

endmodule

`default_nettype wire

/* design/gpr.sv */
`include "cpu_settings.svh"

`default_nettype none

module gpr (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::wb_t      wb,
    input  cpu_pkg::reg_idx_t rd_addr_0,
    input  cpu_pkg::reg_idx_t rd_addr_1,
    output cpu_pkg::word_t    rd_data_0,
    output cpu_pkg::word_t    rd_data_1
);

    cpu_pkg::word_t regs [`GPR_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != '0) begin  // r0 stays zero
            regs[wb.addr] <= wb.data;
        end
    end

    assign rd_data_0 = (rd_addr_0 == '0) ? '0 : regs[rd_addr_0];
    assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];

endmodule

`default_nettype wire

/* design/id_reg.sv */
`default_nettype none

module id_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_en,
    input  cpu_pkg::id_ctrl_t id_in,
    output cpu_pkg::id_ctrl_t id_out
);

    // control bits cleared on reset, operands just follow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_out.valid  <= 1'b0;
            id_out.gpr_we <= 1'b0;
            id_out.mem_op <= cpu_pkg::MEM_NONE;
        end else if (cpu_en) begin
            id_out <= id_in;
        end
    end

endmodule

`default_nettype wire

/* design/decoder.sv */
`include "cpu_settings.svh"

`default_nettype none

module decoder (
    input  cpu_pkg::insn_t    if_insn,
    input  cpu_pkg::waddr_t   if_pc,
    input  logic              if_valid,
    output cpu_pkg::reg_idx_t gpr_rd_addr_0,
    output cpu_pkg::reg_idx_t gpr_rd_addr_1,
    input  cpu_pkg::word_t    gpr_rd_data_0,
    input  cpu_pkg::word_t    gpr_rd_data_1,
    input  cpu_pkg::wb_t      wb,
    output logic              br_taken,
    output cpu_pkg::waddr_t   br_addr,
    output cpu_pkg::id_ctrl_t id_ctrl
);

    logic [`OP_WIDTH-1:0]  op;
    cpu_pkg::reg_idx_t     rd;
    cpu_pkg::reg_idx_t     ra;
    cpu_pkg::reg_idx_t     rb;
    logic [`IMM_WIDTH-1:0] imm;
    cpu_pkg::word_t        imm_sext;
    cpu_pkg::word_t        ra_data;
    cpu_pkg::word_t        rs_data;
    cpu_pkg::alu_op_e      rr_alu_op;

    assign op  = if_insn[`OP_LSB +: `OP_WIDTH];
    assign rd  = if_insn[`RD_LSB +: `REG_IDX_WIDTH];
    assign ra  = if_insn[`RA_LSB +: `REG_IDX_WIDTH];
    assign rb  = if_insn[`RB_LSB +: `REG_IDX_WIDTH];
    assign imm = if_insn[`IMM_WIDTH-1:0];

    assign imm_sext = {{(`DATA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

    // port 1 reads rd for store data and the beq compare
    assign gpr_rd_addr_0 = ra;
    assign gpr_rd_addr_1 = (op == `OP_STORE || op == `OP_BEQ) ? rd : rb;

    // bypass from the instruction in execute
    assign ra_data = (wb.we && wb.addr == gpr_rd_addr_0 && gpr_rd_addr_0 != '0) ?
                     wb.data : gpr_rd_data_0;
    assign rs_data = (wb.we && wb.addr == gpr_rd_addr_1 && gpr_rd_addr_1 != '0) ?
                     wb.data : gpr_rd_data_1;

    assign br_addr = if_pc + cpu_pkg::waddr_t'(1) + imm_sext[`ADDR_WIDTH-1:0];

    always_comb begin
        case (op)
            `OP_SUB: rr_alu_op = cpu_pkg::ALU_SUB;
            `OP_AND: rr_alu_op = cpu_pkg::ALU_AND;
            `OP_OR:  rr_alu_op = cpu_pkg::ALU_OR;
            `OP_XOR: rr_alu_op = cpu_pkg::ALU_XOR;
            `OP_SHL: rr_alu_op = cpu_pkg::ALU_SHL;
            default: rr_alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        br_taken            = 1'b0;
        id_ctrl             = '0;
        id_ctrl.valid       = if_valid;
        id_ctrl.dst         = rd;
        id_ctrl.alu_op      = cpu_pkg::ALU_THRU;
        id_ctrl.alu_in_0    = ra_data;
        id_ctrl.alu_in_1    = rs_data;
        id_ctrl.mem_op      = cpu_pkg::MEM_NONE;
        id_ctrl.store_data  = rs_data;
        if (if_valid) begin
            case (op)
                `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_SHL: begin
                    id_ctrl.alu_op = rr_alu_op;
                    id_ctrl.gpr_we = 1'b1;
                end
                `OP_ADDI: begin
                    id_ctrl.alu_op   = cpu_pkg::ALU_ADD;
                    id_ctrl.alu_in_1 = imm_sext;
                    id_ctrl.gpr_we   = 1'b1;
                end
                `OP_LOAD: begin
                    id_ctrl.alu_op   = cpu_pkg::ALU_ADD;   // byte address
                    id_ctrl.alu_in_1 = imm_sext;
                    id_ctrl.gpr_we   = 1'b1;
                    id_ctrl.mem_op   = cpu_pkg::MEM_LOAD;
                end
                `OP_STORE: begin
                    id_ctrl.alu_op   = cpu_pkg::ALU_ADD;
                    id_ctrl.alu_in_1 = imm_sext;
                    id_ctrl.mem_op   = cpu_pkg::MEM_STORE;
                end
                `OP_BEQ: br_taken = (ra_data == rs_data);
                `OP_JMP: br_taken = 1'b1;
                default: ;  // nop, unknown opcodes fall here too
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/if_stage.sv */
`default_nettype none

module if_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cpu_en,
    input  logic            br_taken,
    input  cpu_pkg::waddr_t br_addr,
    input  cpu_pkg::insn_t  fetch_insn,
    output cpu_pkg::waddr_t pc,
    output cpu_pkg::waddr_t if_pc,
    output cpu_pkg::insn_t  if_insn,
    output logic            if_valid
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (cpu_en) begin
            if (br_taken) begin
                pc <= br_addr;
            end else begin
                pc <= pc + cpu_pkg::waddr_t'(1);
            end
            if_valid <= !br_taken;  // squash the slot fetched alongside a taken branch
        end
    end

    // instruction register, no reset needed
    always_ff @(posedge clk) begin
        if (cpu_en) begin
            if_pc   <= pc;
            if_insn <= fetch_insn;
        end
    end

endmodule

`default_nettype wire

/* common/cpu_pkg.sv */
`include "cpu_settings.svh"

`default_nettype none

package cpu_pkg;

    typedef logic [`DATA_WIDTH-1:0]    word_t;
    typedef logic [`ADDR_WIDTH-1:0]    waddr_t;
    typedef logic [`DATA_WIDTH-1:0]    insn_t;
    typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SHL  = 3'd5,
        ALU_THRU = 3'd6     // pass alu_in_0
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // decode -> execute
    typedef struct packed {
        logic     valid;
        logic     gpr_we;
        reg_idx_t dst;
        alu_op_e  alu_op;
        word_t    alu_in_0;
        word_t    alu_in_1;
        mem_op_e  mem_op;
        word_t    store_data;
    } id_ctrl_t;

    typedef struct packed {
        logic   as_;        // active low strobe
        logic   rw;         // 1 = write
        waddr_t addr;
        word_t  wr_data;
    } spm_req_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* common/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath
`define DATA_WIDTH      32
`define ADDR_WIDTH      30      // word address, byte address >> 2
`define GPR_NUM         32
`define REG_IDX_WIDTH   5
`define SPM_DEPTH       1024    // words

// instruction fields
`define OP_WIDTH        6
`define IMM_WIDTH       16
`define OP_LSB          26
`define RD_LSB          21
`define RA_LSB          16
`define RB_LSB          11

// opcodes
`define OP_NOP          6'h00
`define OP_ADD          6'h01   // rd = ra + rb
`define OP_SUB          6'h02
`define OP_AND          6'h03
`define OP_OR           6'h04
`define OP_XOR          6'h05
`define OP_SHL          6'h06   // rd = ra << rb[4:0]
`define OP_ADDI         6'h07   // rd = ra + sext(imm)
`define OP_LOAD         6'h08   // rd = mem[ra + sext(imm)]
`define OP_STORE        6'h09   // mem[ra + sext(imm)] = rd
`define OP_BEQ          6'h0a   // if (ra == rd) pc = pc + 1 + sext(imm)
`define OP_JMP          6'h0b   // pc = pc + 1 + sext(imm)

`endif
